/* verilog.f */
logic/mem_pkg.sv
logic/load_ctrl.sv
logic/cpu_port_bridge.sv
logic/vram_read_filter.sv
logic/snes_mem_front.sv
test/snes_mem_front_chk.sv
test/tb_checker.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
# build the memory front end testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top \
    -f verilog.f -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep going after assertion errors so the testbench prints its summary
./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0

/* test/tb_top.sv */
/*
 * testbench top for the memory front end: clock, reset, xorshift stimulus, watchdog.
 * tb_checker does the comparing; the closing summary decides the result
 */
`timescale 1ns/1ps

module tb_top import mem_pkg::*; ();

    localparam int RESET_CYC  = 4;
    localparam int LOAD_BYTES = 48;
    // a byte needs two cycles of handshake, six leaves slack
    localparam int LOAD_CYC   = LOAD_BYTES * 6 + 4;
    localparam int RUN_CYC    = 400;
    localparam int TOTAL_CYC  = RESET_CYC + LOAD_CYC + 5 * RUN_CYC;

    logic        wclk = 1'b0;
    logic        resetn;
    snes_bus_t   snes;
    vram_bus_t   vram;
    logic        sysclkf_ce;
    logic        sysclkr_ce;
    logic [7:0]  rom_type;
    logic        loading;
    logic        loader_req;
    logic [7:0]  loader_byte;
    logic        loader_ack;
    logic        sdram_busy;
    logic        pause;
    logic        enable;
    logic        loaded;
    logic [15:0] cpu_port0;
    logic [15:0] cpu_port1;
    cpu_req_t    cpu_req;
    bsram_req_t  bsram_req;
    vram_req_t   vram_req;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;
    logic [31:0] seed = 32'd44;

    snes_mem_front i_dut (.*);
    tb_checker i_chk (.*);

    always #20 wclk = ~wclk;

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // new random bus values, mode picks the bias of each test
    task automatic drive_random(input int mode);
        logic [31:0] r;
        logic [31:0] s;
        logic [95:0] bits;
        logic [63:0] vbits;
        vram_bus_t   v;
        r     = next_rand();
        s     = next_rand();
        bits  = {next_rand(), next_rand(), next_rand()};
        vbits = {next_rand(), next_rand()};
        snes  = bits[$bits(snes_bus_t)-1:0];
        // strobes leaning toward active
        snes.rom_ce_n   = r[0] & r[1];
        snes.wram_ce_n  = r[2];
        snes.wram_rd_n  = r[3];
        snes.wram_we_n  = ~r[3] | r[4];
        snes.bsram_ce_n = (mode == 4) ? (r[5] & r[6]) : r[5];
        snes.bsram_rd_n = r[7];
        snes.bsram_we_n = ~r[7] | r[8];
        // fall and rise phases never in the same cycle
        sysclkf_ce = (r[10:9] == 2'd0);
        sysclkr_ce = (r[10:9] == 2'd1);
        rom_type[7:4] = r[11] ? ROM_TYPE_BSRAM_RD : 4'h2;
        rom_type[3:0] = r[15:12];
        if (mode == 2) begin
            sdram_busy = r[16];
            pause      = r[17] & r[18];
        end else begin
            sdram_busy = (r[18:16] == 3'd0);
            pause      = (r[21:19] == 3'd0);
        end
        cpu_port0 = s[15:0];
        cpu_port1 = s[31:16];
        // mostly held addresses, so reads repeat
        v = vbits[$bits(vram_bus_t)-1:0];
        if (r[23:22] != 2'd0) begin
            v.vram1_addr = vram.vram1_addr;
            v.vram2_addr = vram.vram2_addr;
        end
        if (r[25:24] == 2'd0)
            v.vram2_addr = v.vram1_addr;
        v.vram_oe_n = (mode == 5) ? (r[26] & r[27]) : r[26];
        vram = v;
        // loader source keeps to the four-phase order
        if (mode >= 3) begin
            if (loader_req & loader_ack)
                loader_req = 1'b0;
            else if (~loader_req & ~loader_ack & r[28] & r[29]) begin
                loader_req  = 1'b1;
                loader_byte = bits[95:88];
            end
        end
    endtask

    task automatic step(input int mode);
        drive_random(mode);
        @(posedge wclk);
        #2;
    endtask

    task automatic send_byte(input logic [7:0] b);
        loader_byte = b;
        loader_req  = 1'b1;
        step(1);
        while (loader_ack !== 1'b1)
            step(1);
        loader_req = 1'b0;
        step(1);
        while (loader_ack !== 1'b0)
            step(1);
    endtask

    initial begin
        logic [31:0] r;
        resetn      = 1'b0;
        snes        = '1;
        vram        = '1;
        sysclkf_ce  = 1'b0;
        sysclkr_ce  = 1'b0;
        rom_type    = 8'h00;
        loading     = 1'b0;
        loader_req  = 1'b0;
        loader_byte = 8'h00;
        sdram_busy  = 1'b0;
        pause       = 1'b0;
        cpu_port0   = 16'h0000;
        cpu_port1   = 16'h0000;
        repeat (RESET_CYC) @(posedge wclk);
        #2;
        resetn = 1'b1;

        loading = 1'b1;
        step(1);
        for (int i = 0; i < LOAD_BYTES; i++) begin
            r = next_rand();
            send_byte(r[7:0]);
        end
        loading = 1'b0;
        step(1);
        i_chk.end_test("loader writes");
        repeat (RUN_CYC) step(2);
        i_chk.end_test("loaded flag and run enable");
        repeat (RUN_CYC) step(3);
        i_chk.end_test("cpu-port requests");
        repeat (RUN_CYC) step(4);
        i_chk.end_test("battery-RAM requests");
        repeat (RUN_CYC) step(5);
        i_chk.end_test("VRAM filtering");
        repeat (RUN_CYC) step(6);
        i_chk.end_test("read-data steering");

        $display("summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
                 i_chk.checks, i_chk.errors, i_dut.i_sva.fails);
        if (i_chk.errors == 0 && i_dut.i_sva.fails == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // watchdog, sized from the test lengths plus a margin
    initial begin
        #(TOTAL_CYC * 40 + 2000);
        $display("timeout: tests did not finish within %0d cycles", TOTAL_CYC);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* test/tb_checker.sv */
/*
 * cycle model of the memory front end, compared with the DUT on every falling edge.
 * tb_top calls end_test when a test finishes
 */
`timescale 1ns/1ps

module tb_checker import mem_pkg::*; (
    input logic        wclk,
    input logic        resetn,
    input snes_bus_t   snes,
    input vram_bus_t   vram,
    input logic        sysclkf_ce,
    input logic        sysclkr_ce,
    input logic [7:0]  rom_type,
    input logic        loading,
    input logic        loader_req,
    input logic [7:0]  loader_byte,
    input logic        sdram_busy,
    input logic        pause,
    input logic [15:0] cpu_port0,
    input logic [15:0] cpu_port1,
    input logic        loader_ack,
    input logic        enable,
    input logic        loaded,
    input cpu_req_t    cpu_req,
    input bsram_req_t  bsram_req,
    input vram_req_t   vram_req,
    input logic [15:0] rom_q,
    input logic [7:0]  wram_q
);

    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int test_checks = 0;
    int test_num = 0;

    // model state
    logic        ack_m, wr_valid_m, loading_q, loaded_m;
    logic        enable_m, f2_m, r2_m, oe_n_q, defer_m;
    logic [23:0] next_addr_m;
    logic [23:0] wr_addr_m;
    logic [7:0]  wr_byte_m;
    logic [14:0] a1_q;
    logic [14:0] a2_q;
    cpu_req_t    cpu_m;
    cpu_req_t    cpu_exp;
    bsram_req_t  bsram_m;
    vram_req_t   vram_exp;
    data_word_u  dup_w;
    data_word_u  rom_w;
    data_word_u  wram_w;
    logic [15:0] rom_exp;
    logic        take, bs_rd, rd1, rd2, clash;

    assign take  = loader_req & ~ack_m;
    assign bs_rd = ~snes.bsram_ce_n & f2_m
                 & (~snes.bsram_rd_n | (rom_type[7:4] == ROM_TYPE_BSRAM_RD));
    // oe just fell, or the port moved
    assign rd1   = ~vram.vram_oe_n & (oe_n_q | (a1_q != vram.vram1_addr[14:0]));
    assign rd2   = ~vram.vram_oe_n & (oe_n_q | (a2_q != vram.vram2_addr[14:0]));
    assign clash = rd1 & rd2 & (vram.vram1_addr != vram.vram2_addr);

    // expected next cpu-port request
    always_comb begin
        cpu_exp    = '0;
        dup_w.word = '0;
        if (wr_valid_m) begin
            dup_w.b.hi   = wr_byte_m;
            dup_w.b.lo   = wr_byte_m;
            cpu_exp.addr = wr_addr_m[22:0];
            cpu_exp.ds   = wr_addr_m[0] ? 2'b10 : 2'b01;
            cpu_exp.din  = dup_w.word;
            cpu_exp.wr   = 1'b1;
        end else if (~snes.rom_ce_n & f2_m & ~bs_rd) begin
            cpu_exp.addr = snes.rom_addr[22:0];
            cpu_exp.ds   = 2'b11;
            cpu_exp.rd   = 1'b1;
        end else if (~snes.wram_ce_n & (~snes.wram_rd_n | ~snes.wram_we_n)) begin
            dup_w.b.hi   = snes.wram_d;
            dup_w.b.lo   = snes.wram_d;
            cpu_exp.addr = {WRAM_BANK_PREFIX, snes.wram_addr};
            cpu_exp.ds   = snes.wram_addr[0] ? 2'b10 : 2'b01;
            cpu_exp.din  = dup_w.word;
            cpu_exp.port = 1'b1;
            cpu_exp.rd   = ~snes.wram_rd_n & f2_m;
            cpu_exp.wr   = ~snes.wram_we_n & r2_m;
        end
    end

    assign vram_exp = {rd1, (rd2 & ~clash) | defer_m, ~vram.vram1_we_n, ~vram.vram2_we_n,
                       vram.vram1_addr[14:0], vram.vram2_addr[14:0], vram.vram1_d, vram.vram2_d};
    assign rom_w.word  = cpu_port0;
    assign wram_w.word = cpu_port1;
    // odd byte, not a word fetch
    assign rom_exp = (snes.rom_addr[0] & ~snes.rom_word) ? {rom_w.b.lo, rom_w.b.hi} : rom_w.word;

    always @(posedge wclk) begin
        if (!resetn) begin
            ack_m       <= 1'b0;
            wr_valid_m  <= 1'b0;
            loading_q   <= 1'b0;
            loaded_m    <= 1'b0;
            enable_m    <= 1'b0;
            f2_m        <= 1'b0;
            r2_m        <= 1'b0;
            oe_n_q      <= 1'b1;
            defer_m     <= 1'b0;
            next_addr_m <= '0;
            cpu_m       <= '0;
            bsram_m.rd  <= 1'b0;
            bsram_m.wr  <= 1'b0;
        end else begin
            wr_valid_m <= take;
            ack_m      <= take | (ack_m & loader_req);
            if (take) begin
                wr_addr_m <= next_addr_m;
                wr_byte_m <= loader_byte;
            end
            if (loading & ~loading_q)
                next_addr_m <= '0;
            else if (take)
                next_addr_m <= next_addr_m + 24'd1;
            loading_q <= loading;
            if (loading & ~loading_q)
                loaded_m <= 1'b0;
            else if (~loading & loading_q)
                loaded_m <= 1'b1;
            enable_m   <= ~sdram_busy & ~pause & loaded_m;
            f2_m       <= sysclkf_ce & enable_m;
            r2_m       <= sysclkr_ce & enable_m;
            cpu_m      <= cpu_exp;
            bsram_m.rd <= bs_rd;
            bsram_m.wr <= ~snes.bsram_ce_n & ~snes.bsram_we_n & r2_m;
            oe_n_q     <= vram.vram_oe_n;
            defer_m    <= clash;
        end
        a1_q         <= vram.vram1_addr[14:0];
        a2_q         <= vram.vram2_addr[14:0];
        bsram_m.addr <= snes.bsram_addr;
        bsram_m.din  <= snes.bsram_d;
    end

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0t ns: %s is %h, model expects %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // inputs move 2 ns after the rising edge, so mid-cycle is settled
    always @(negedge wclk) begin
        if (resetn) begin
            compare("loader_ack", 64'(loader_ack), 64'(ack_m));
            compare("loaded", 64'(loaded), 64'(loaded_m));
            compare("enable", 64'(enable), 64'(enable_m));
            compare("cpu_req", 64'(cpu_req), 64'(cpu_m));
            compare("bsram_req", 64'(bsram_req), 64'(bsram_m));
            compare("vram_req", 64'(vram_req), 64'(vram_exp));
            compare("rom_q", 64'(rom_q), 64'(rom_exp));
            compare("wram_q", 64'(wram_q), 64'(snes.wram_addr[0] ? wram_w.b.hi : wram_w.b.lo));
        end
    end

endmodule

/* test/snes_mem_front_chk.sv */
/*
 * concurrent assertions on the loader handshake and request strobes.
 * bound into the front end top level
 */
`timescale 1ns/1ps

module snes_mem_front_chk import mem_pkg::*; (
    input logic      wclk,
    input logic      resetn,
    input logic      loader_req,
    input logic      loader_ack,
    input cpu_req_t  cpu_req,
    input vram_bus_t vram,
    input vram_req_t vram_req
);

    int fails = 0;

    logic               oe_n_q;
    logic [VRAM_AW-1:0] a2_q;
    logic               clash;
    logic               clash_q;

    // both ports start a read to different places this cycle
    assign clash = vram_req.vram1_rd & ~vram.vram_oe_n
                 & (oe_n_q | (a2_q != vram.vram2_addr[VRAM_AW-1:0]))
                 & (vram.vram1_addr != vram.vram2_addr);

    always_ff @(posedge wclk) begin
        oe_n_q  <= vram.vram_oe_n;
        a2_q    <= vram.vram2_addr[VRAM_AW-1:0];
        clash_q <= clash;
    end

    // ack only ever answers a raised req
    assert property (@(posedge wclk) disable iff (!resetn)
        $rose(loader_ack) |-> $past(loader_req))
    else begin
        fails++;
        $error("loader_ack rose while loader_req was low");
    end

    assert property (@(posedge wclk) disable iff (!resetn)
        !(cpu_req.rd && cpu_req.wr))
    else begin
        fails++;
        $error("cpu_req rd and wr high together");
    end

    // port 2 stays quiet while its read waits
    assert property (@(posedge wclk) disable iff (!resetn)
        (clash && !clash_q) |-> !vram_req.vram2_rd)
    else begin
        fails++;
        $error("vram2 read issued while deferred");
    end

endmodule

bind snes_mem_front snes_mem_front_chk i_sva (
    .wclk       (wclk),
    .resetn     (resetn),
    .loader_req (loader_req),
    .loader_ack (loader_ack),
    .cpu_req    (cpu_req),
    .vram       (vram),
    .vram_req   (vram_req)
);

/* logic/snes_mem_front.sv */
/*
 * memory front end between the console buses and the shared sdram controller.
 * loader, cpu-port bridge and vram filter side by side
 */
`timescale 1ns/1ps

module snes_mem_front import mem_pkg::*; #(
    parameter int VRAM_AW = mem_pkg::VRAM_AW
) (
    input  logic        wclk,
    input  logic        resetn,

    // console side
    input  snes_bus_t   snes,
    input  vram_bus_t   vram,
    input  logic        sysclkf_ce,
    input  logic        sysclkr_ce,
    input  logic [7:0]  rom_type,

    // cartridge loader
    input  logic        loading,
    input  logic        loader_req,
    input  logic [7:0]  loader_byte,
    output logic        loader_ack,

    // run control
    input  logic        sdram_busy,
    input  logic        pause,
    output logic        enable,
    output logic        loaded,

    // sdram controller
    input  logic [15:0] cpu_port0,
    input  logic [15:0] cpu_port1,
    output cpu_req_t    cpu_req,
    output bsram_req_t  bsram_req,
    output vram_req_t   vram_req,

    // read data back to the console
    output logic [15:0] rom_q,
    output logic [7:0]  wram_q
);

    // accepted loader byte, into the cpu port
    load_wr_t load_wr;

    load_ctrl i_load_ctrl (
        .wclk        (wclk),
        .resetn      (resetn),
        .loading     (loading),
        .loader_req  (loader_req),
        .loader_byte (loader_byte),
        .sdram_busy  (sdram_busy),
        .pause       (pause),
        .loader_ack  (loader_ack),
        .load_wr     (load_wr),
        .loaded      (loaded),
        .enable      (enable)
    );

    cpu_port_bridge i_cpu_port_bridge (
        .wclk       (wclk),
        .resetn     (resetn),
        .snes       (snes),
        .rom_type   (rom_type),
        .sysclkf_ce (sysclkf_ce),
        .sysclkr_ce (sysclkr_ce),
        .enable     (enable),
        .load_wr    (load_wr),
        .cpu_port0  (cpu_port0),
        .cpu_port1  (cpu_port1),
        .cpu_req    (cpu_req),
        .bsram_req  (bsram_req),
        .rom_q      (rom_q),
        .wram_q     (wram_q)
    );

    vram_read_filter #(
        .VRAM_AW (VRAM_AW)
    ) i_vram_read_filter (
        .wclk     (wclk),
        .resetn   (resetn),
        .vram     (vram),
        .vram_req (vram_req)
    );

endmodule

/* logic/vram_read_filter.sv */
/*
 * turns the ppu vram strobes into controller requests.
 * drops repeated reads and pushes a colliding port 2 read back one cycle
 */
`timescale 1ns/1ps

module vram_read_filter import mem_pkg::*; #(
    parameter int VRAM_AW = mem_pkg::VRAM_AW
) (
    input  logic      wclk,
    input  logic      resetn,
    input  vram_bus_t vram,
    output vram_req_t vram_req
);

    // last cycle's view of the bus
    logic [VRAM_AW-1:0] vram1_addr_old;
    logic [VRAM_AW-1:0] vram2_addr_old;
    logic               vram_oe_n_old;
    logic               vram2_read_delay_r;

    logic vram1_new_read;
    logic vram2_new_read;
    logic vram2_read_delay;

    // a read held over several cycles counts once
    assign vram1_new_read = ~vram.vram_oe_n
                          & (vram_oe_n_old | (vram1_addr_old != vram.vram1_addr[VRAM_AW-1:0]));
    assign vram2_new_read = ~vram.vram_oe_n
                          & (vram_oe_n_old | (vram2_addr_old != vram.vram2_addr[VRAM_AW-1:0]));

    // controller takes one read per cycle when addresses differ
    assign vram2_read_delay = vram1_new_read & vram2_new_read
                            & (vram.vram1_addr != vram.vram2_addr);

    always_ff @(posedge wclk) begin
        if (~resetn) begin
            vram_oe_n_old      <= 1'b1;
            vram2_read_delay_r <= 1'b0;
        end else begin
            vram_oe_n_old      <= vram.vram_oe_n;
            vram2_read_delay_r <= vram2_read_delay;
        end
    end

    always_ff @(posedge wclk) begin
        vram1_addr_old <= vram.vram1_addr[VRAM_AW-1:0];
        vram2_addr_old <= vram.vram2_addr[VRAM_AW-1:0];
    end

    // same-cycle pass through apart from the deferred port 2 read
    assign vram_req.vram1_rd   = vram1_new_read;
    assign vram_req.vram2_rd   = (vram2_new_read & ~vram2_read_delay) | vram2_read_delay_r;
    assign vram_req.vram1_wr   = ~vram.vram1_we_n;
    assign vram_req.vram2_wr   = ~vram.vram2_we_n;
    assign vram_req.vram1_addr = vram.vram1_addr[VRAM_AW-1:0];
    assign vram_req.vram2_addr = vram.vram2_addr[VRAM_AW-1:0];
    assign vram_req.vram1_din  = vram.vram1_d;
    assign vram_req.vram2_din  = vram.vram2_d;

endmodule

/* logic/cpu_port_bridge.sv */
/*
 * builds the sdram cpu-port and battery ram requests from console strobes.
 * also steers returned sdram words back onto the byte-wide rom and wram buses
 */
`timescale 1ns/1ps

module cpu_port_bridge import mem_pkg::*; (
    input  logic        wclk,
    input  logic        resetn,
    input  snes_bus_t   snes,
    input  logic [7:0]  rom_type,
    input  logic        sysclkf_ce,
    input  logic        sysclkr_ce,
    input  logic        enable,
    input  load_wr_t    load_wr,
    input  logic [15:0] cpu_port0,
    input  logic [15:0] cpu_port1,
    output cpu_req_t    cpu_req,
    output bsram_req_t  bsram_req,
    output logic [15:0] rom_q,
    output logic [7:0]  wram_q
);

    // fall / rise phases, one cycle behind the console enables
    logic f2;
    logic r2;

    logic       wram_rd;
    logic       wram_wr;
    logic       bsram_rd_t;
    logic       bsram_wr_t;
    cpu_req_t   cpu_req_nxt;
    data_word_u rom_word_in;
    data_word_u wram_word_in;
    data_word_u wram_din_w;
    data_word_u load_din_w;

    assign wram_rd = ~snes.wram_ce_n & ~snes.wram_rd_n;
    assign wram_wr = ~snes.wram_ce_n & ~snes.wram_we_n;

    // some cart types read bsram without a read strobe
    assign bsram_rd_t = ~snes.bsram_ce_n & f2
                      & (~snes.bsram_rd_n | (rom_type[7:4] == ROM_TYPE_BSRAM_RD));
    assign bsram_wr_t = ~snes.bsram_ce_n & ~snes.bsram_we_n & r2;

    // write bytes go out on both lanes, ds picks the real one
    assign wram_din_w.b.hi = snes.wram_d;
    assign wram_din_w.b.lo = snes.wram_d;
    assign load_din_w.b.hi = load_wr.data;
    assign load_din_w.b.lo = load_wr.data;

    always_ff @(posedge wclk) begin
        if (~resetn) begin
            f2 <= 1'b0;
            r2 <= 1'b0;
        end else begin
            f2 <= sysclkf_ce & enable;
            r2 <= sysclkr_ce & enable;
        end
    end

    // one cpu-port request per cycle
    // loader first, then rom, then wram
    always_comb begin
        cpu_req_nxt = '0;
        if (load_wr.valid) begin
            cpu_req_nxt.addr = load_wr.addr[SDRAM_AW-1:0];
            cpu_req_nxt.ds   = {load_wr.addr[0], ~load_wr.addr[0]};
            cpu_req_nxt.din  = load_din_w.word;
            cpu_req_nxt.wr   = 1'b1;
        end else if (~snes.rom_ce_n & ~bsram_rd_t & f2) begin
            // rom reads are always full words
            cpu_req_nxt.addr = snes.rom_addr[SDRAM_AW-1:0];
            cpu_req_nxt.ds   = 2'b11;
            cpu_req_nxt.rd   = 1'b1;
        end else if (wram_rd | wram_wr) begin
            // 7E/7F banks map to the top of sdram
            cpu_req_nxt.addr = {WRAM_BANK_PREFIX, snes.wram_addr};
            cpu_req_nxt.ds   = {snes.wram_addr[0], ~snes.wram_addr[0]};
            cpu_req_nxt.din  = wram_din_w.word;
            cpu_req_nxt.port = 1'b1;
            cpu_req_nxt.rd   = wram_rd & f2;
            cpu_req_nxt.wr   = wram_wr & r2;
        end
    end

    // controller samples these at fixed timing
    always_ff @(posedge wclk) begin
        if (~resetn)
            cpu_req <= '0;
        else
            cpu_req <= cpu_req_nxt;
    end

    // bsram strobes
    always_ff @(posedge wclk) begin
        if (~resetn) begin
            bsram_req.rd <= 1'b0;
            bsram_req.wr <= 1'b0;
        end else begin
            bsram_req.rd <= bsram_rd_t;
            bsram_req.wr <= bsram_wr_t;
        end
    end

    // bsram address and data, captured every cycle
    always_ff @(posedge wclk) begin
        bsram_req.addr <= snes.bsram_addr;
        bsram_req.din  <= snes.bsram_d;
    end

    // read data back to the console
    assign rom_word_in.word  = cpu_port0;
    assign wram_word_in.word = cpu_port1;

    // odd byte reads need the high byte moved down
    always_comb begin
        if (snes.rom_word | ~snes.rom_addr[0])
            rom_q = rom_word_in.word;
        else
            rom_q = {rom_word_in.b.lo, rom_word_in.b.hi};
    end

    assign wram_q = snes.wram_addr[0] ? wram_word_in.b.hi : wram_word_in.b.lo;

endmodule

/* logic/load_ctrl.sv */
/*
 * cartridge loader handshake, loader address and loaded flag.
 * also produces the registered console run enable
 */
`timescale 1ns/1ps

module load_ctrl import mem_pkg::*; (
    input  logic       wclk,
    input  logic       resetn,
    input  logic       loading,
    input  logic       loader_req,
    input  logic [7:0] loader_byte,
    input  logic       sdram_busy,
    input  logic       pause,
    output logic       loader_ack,
    output load_wr_t   load_wr,
    output logic       loaded,
    output logic       enable
);

    logic [23:0] loader_addr;
    logic        loading_r;
    logic        accept;

    // take a byte only when req is up and ack is down
    assign accept = loader_req & ~loader_ack;

    // handshake and byte capture
    always_ff @(posedge wclk) begin
        if (~resetn) begin
            loader_ack    <= 1'b0;
            load_wr.valid <= 1'b0;
        end else begin
            load_wr.valid <= accept;
            if (accept)
                loader_ack <= 1'b1;
            else if (~loader_req)
                loader_ack <= 1'b0;
        end
    end

    // payload of the accepted byte
    always_ff @(posedge wclk) begin
        if (accept) begin
            load_wr.addr <= loader_addr;
            load_wr.data <= loader_byte;
        end
    end

    // loader address and loaded flag from loading edges
    always_ff @(posedge wclk) begin
        if (~resetn) begin
            loading_r   <= 1'b0;
            loaded      <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_r <= loading;
            if (accept)
                loader_addr <= loader_addr + 24'd1;
            // a new load restarts at zero and wins over the increment
            if (loading & ~loading_r) begin
                loader_addr <= '0;
                loaded      <= 1'b0;
            end
            if (~loading & loading_r)
                loaded <= 1'b1;
        end
    end

    // console runs only when memory is idle and a cart is in
    always_ff @(posedge wclk) begin
        if (~resetn)
            enable <= 1'b0;
        else
            enable <= ~sdram_busy & ~pause & loaded;
    end

endmodule

/* logic/mem_pkg.sv */
/*
 * shared types and constants for the console memory front end.
 * imported by every block that touches the request or bus structs
 */
package mem_pkg;

    // cpu port byte address width
    localparam int SDRAM_AW = 23;
    // wram sits at the top 128KB of sdram
    localparam logic [5:0] WRAM_BANK_PREFIX = 6'b111111;
    // upper nibble of rom_type where bsram reads ignore rd_n
    localparam logic [3:0] ROM_TYPE_BSRAM_RD = 4'hC;
    // vram address bits forwarded to the controller
    localparam int VRAM_AW = 15;

    // console side strobes, all active low as on the console
    typedef struct packed {
        logic [23:0] rom_addr;
        logic        rom_ce_n;
        logic        rom_word;
        logic [16:0] wram_addr;
        logic [7:0]  wram_d;
        logic        wram_ce_n;
        logic        wram_rd_n;
        logic        wram_we_n;
        logic [19:0] bsram_addr;
        logic [7:0]  bsram_d;
        logic        bsram_ce_n;
        logic        bsram_rd_n;
        logic        bsram_we_n;
    } snes_bus_t;

    // both ppu vram ports, shared oe
    typedef struct packed {
        logic [15:0] vram1_addr;
        logic [15:0] vram2_addr;
        logic        vram1_we_n;
        logic        vram2_we_n;
        logic        vram_oe_n;
        logic [7:0]  vram1_d;
        logic [7:0]  vram2_d;
    } vram_bus_t;

    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [1:0]          ds;
        logic [15:0]         din;
        logic                port;
        logic                rd;
        logic                wr;
    } cpu_req_t;

    typedef struct packed {
        logic [19:0] addr;
        logic [7:0]  din;
        logic        rd;
        logic        wr;
    } bsram_req_t;

    typedef struct packed {
        logic               vram1_rd;
        logic               vram2_rd;
        logic               vram1_wr;
        logic               vram2_wr;
        logic [VRAM_AW-1:0] vram1_addr;
        logic [VRAM_AW-1:0] vram2_addr;
        logic [7:0]         vram1_din;
        logic [7:0]         vram2_din;
    } vram_req_t;

    // one accepted loader byte
    typedef struct packed {
        logic [23:0] addr;
        logic [7:0]  data;
        logic        valid;
    } load_wr_t;

    // sdram word, seen whole or as two bytes
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } b;
    } data_word_u;

endpackage
